//--- verilog/snn_pkg.sv
package snn_pkg;

    // Data widths
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;   // Signed
    localparam int POT_W    = 16;  // Signed membrane potential
    localparam int COUNT_W  = 16;
    localparam int STEP_W   = 8;

    // Output layer, ten classes
    localparam int NUM_OUT  = 10;
    localparam int OUT_ID_W = 4;

    typedef logic        [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [POT_W-1:0]    pot_t;
    typedef logic        [OUT_ID_W-1:0] out_id_t;
    typedef logic        [COUNT_W-1:0]  count_t;

    // Encoder sequencing
    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_SCAN,       // Walk pixels, emit events
        ENC_DRAIN,      // Wait for all credits back
        ENC_WAIT_STEP   // Wait for fire pass
    } enc_state_t;

    // Neuron array sequencing
    typedef enum logic [1:0] {
        NRN_IDLE,
        NRN_INTEG,
        NRN_FIRE
    } nrn_state_t;

endpackage

//--- verilog/rate_encoder.sv
`timescale 1ns/10ps

module rate_encoder #(
    parameter int NUM_IN    = 16,
    parameter int IN_ADDR_W = 4,
    parameter int CREDITS   = 4
) (
    input  logic                       SNN_CLK,
    input  logic                       RST_N,
    input  logic                       pix_we,
    input  logic [IN_ADDR_W-1:0]       pix_addr,
    input  snn_pkg::pixel_t            pix_data,
    input  logic                       start,
    input  logic [snn_pkg::STEP_W-1:0] num_steps,
    output logic                       busy,
    output logic                       ev_valid,
    output logic [IN_ADDR_W-1:0]       ev_addr,
    input  logic                       ev_credit,
    output logic                       step_end,
    output logic                       run_last,
    input  logic                       step_done
);

    localparam int CRED_W = $clog2(CREDITS + 1);

    snn_pkg::enc_state_t        state;
    snn_pkg::pixel_t            pix_mem [NUM_IN];
    snn_pkg::pixel_t            acc     [NUM_IN];  // Phase accumulators
    logic [IN_ADDR_W-1:0]       pix_idx;
    logic [snn_pkg::STEP_W-1:0] step_cnt;
    logic [snn_pkg::STEP_W-1:0] steps_r;
    logic [CRED_W-1:0]          credit_cnt;
    logic                       finish;
    logic [snn_pkg::PIXEL_W:0]  acc_sum;
    logic                       carry;
    logic                       advance;
    logic                       spend;
    logic                       last_pix;
    logic                       last_step;

    assign acc_sum   = {1'b0, acc[pix_idx]} + {1'b0, pix_mem[pix_idx]};
    assign carry     = acc_sum[snn_pkg::PIXEL_W];  // Wrap of the phase means a spike
    // Hold the pixel while a spike is due and no credit is left
    assign advance   = (state == snn_pkg::ENC_SCAN) && (!carry || credit_cnt != '0);
    assign spend     = advance && carry;
    assign last_pix  = pix_idx == IN_ADDR_W'(NUM_IN - 1);
    assign last_step = step_cnt == steps_r - 1'b1;

    always_ff @(posedge SNN_CLK) begin
        if (pix_we && !busy) begin
            pix_mem[pix_addr] <= pix_data;
        end
    end

    always_ff @(posedge SNN_CLK) begin
        if (start && !busy) begin
            for (int i = 0; i < NUM_IN; i++) begin
                acc[i] <= '0;
            end
        end else if (advance) begin
            acc[pix_idx] <= acc_sum[snn_pkg::PIXEL_W-1:0];
        end
    end

    // Credits leave with each event and come back as the array retires it
    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            credit_cnt <= CRED_W'(CREDITS);
        end else if (start && !busy) begin
            credit_cnt <= CRED_W'(CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CRED_W'(spend) + CRED_W'(ev_credit);
        end
    end

    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            state    <= snn_pkg::ENC_IDLE;
            busy     <= 1'b0;
            finish   <= 1'b0;
            pix_idx  <= '0;
            step_cnt <= '0;
            steps_r  <= '0;
            ev_valid <= 1'b0;
            ev_addr  <= '0;
            step_end <= 1'b0;
            run_last <= 1'b0;
        end else begin
            ev_valid <= spend;
            step_end <= 1'b0;
            if (spend) begin
                ev_addr <= pix_idx;
            end
            // One cycle tail so busy drops together with the tally's done
            if (finish) begin
                busy   <= 1'b0;
                finish <= 1'b0;
            end
            case (state)
                snn_pkg::ENC_IDLE: begin
                    if (start && !busy) begin
                        busy     <= 1'b1;
                        steps_r  <= num_steps;
                        step_cnt <= '0;
                        pix_idx  <= '0;
                        state    <= snn_pkg::ENC_SCAN;
                    end
                end
                snn_pkg::ENC_SCAN: begin
                    if (advance) begin
                        if (last_pix) begin
                            pix_idx <= '0;
                            state   <= snn_pkg::ENC_DRAIN;
                        end else begin
                            pix_idx <= pix_idx + 1'b1;
                        end
                    end
                end
                snn_pkg::ENC_DRAIN: begin
                    if (credit_cnt == CRED_W'(CREDITS)) begin  // Array queue empty
                        step_end <= 1'b1;
                        run_last <= last_step;
                        state    <= snn_pkg::ENC_WAIT_STEP;
                    end
                end
                snn_pkg::ENC_WAIT_STEP: begin
                    if (step_done) begin
                        if (run_last) begin
                            finish <= 1'b1;
                            state  <= snn_pkg::ENC_IDLE;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            state    <= snn_pkg::ENC_SCAN;
                        end
                    end
                end
                default: state <= snn_pkg::ENC_IDLE;
            endcase
        end
    end

    a_credit_max: assert property (@(posedge SNN_CLK) disable iff (!RST_N)
        credit_cnt <= CRED_W'(CREDITS));

    // An event on the wire still holds its credit
    a_event_has_credit: assert property (@(posedge SNN_CLK) disable iff (!RST_N)
        ev_valid |-> credit_cnt != CRED_W'(CREDITS));

endmodule

//--- verilog/neuron_array.sv
`timescale 1ns/10ps

module neuron_array #(
    parameter int NUM_IN     = 16,
    parameter int IN_ADDR_W  = 4,
    parameter int CREDITS    = 4,
    parameter int THRESHOLD  = 200,
    parameter int LEAK_SHIFT = 3
) (
    input  logic                 SNN_CLK,
    input  logic                 RST_N,
    input  logic                 w_we,
    input  logic [IN_ADDR_W-1:0] w_in_addr,
    input  snn_pkg::out_id_t     w_out_id,
    input  snn_pkg::weight_t     w_data,
    input  logic                 start,
    input  logic                 ev_valid,
    input  logic [IN_ADDR_W-1:0] ev_addr,
    output logic                 ev_credit,
    input  logic                 step_end,
    input  logic                 run_last,
    output logic                 step_done,
    output logic                 spike_valid,
    output snn_pkg::out_id_t     spike_id,
    output logic                 clear,
    output logic                 fire_last
);

    localparam int QA_W  = $clog2(CREDITS);
    localparam int QC_W  = $clog2(CREDITS + 1);
    localparam int SUM_W = snn_pkg::POT_W + 1;

    snn_pkg::nrn_state_t  state;
    snn_pkg::weight_t     w_mem [NUM_IN][snn_pkg::NUM_OUT];
    snn_pkg::pot_t        pot   [snn_pkg::NUM_OUT];
    logic [IN_ADDR_W-1:0] q_mem [CREDITS];  // Event queue
    logic [QA_W-1:0]      q_wr;
    logic [QA_W-1:0]      q_rd;
    logic [QC_W-1:0]      q_cnt;
    logic                 q_pop;
    snn_pkg::out_id_t     nrn_idx;
    logic                 last_r;
    logic                 active;
    logic                 fire_last_d;
    logic                 run_start;
    logic                 last_nrn;
    logic                 fire;
    snn_pkg::pot_t        pot_cur;
    snn_pkg::pot_t        pot_sat;
    snn_pkg::pot_t        pot_leak;
    snn_pkg::weight_t     wt;
    logic signed [SUM_W-1:0] sum;

    assign run_start = start && !active;
    assign last_nrn  = nrn_idx == snn_pkg::out_id_t'(snn_pkg::NUM_OUT - 1);
    assign q_pop     = (state == snn_pkg::NRN_INTEG) && last_nrn;

    assign pot_cur  = pot[nrn_idx];
    assign wt       = w_mem[q_mem[q_rd]][nrn_idx];
    assign sum      = SUM_W'(pot_cur) + SUM_W'(wt);
    assign fire     = pot_cur >= snn_pkg::pot_t'(THRESHOLD);
    assign pot_leak = pot_cur - (pot_cur >>> LEAK_SHIFT);

    // Clamp to the signed potential range
    always_comb begin
        if (sum[SUM_W-1] != sum[SUM_W-2]) begin
            pot_sat = sum[SUM_W-1] ? {1'b1, {(snn_pkg::POT_W-1){1'b0}}}
                                   : {1'b0, {(snn_pkg::POT_W-1){1'b1}}};
        end else begin
            pot_sat = sum[snn_pkg::POT_W-1:0];
        end
    end

    always_ff @(posedge SNN_CLK) begin
        if (w_we && !active) begin
            w_mem[w_in_addr][w_out_id] <= w_data;
        end
        if (ev_valid) begin
            q_mem[q_wr] <= ev_addr;
        end
    end

    always_ff @(posedge SNN_CLK) begin
        if (run_start) begin
            for (int i = 0; i < snn_pkg::NUM_OUT; i++) begin
                pot[i] <= '0;
            end
        end else if (state == snn_pkg::NRN_INTEG) begin
            pot[nrn_idx] <= pot_sat;
        end else if (state == snn_pkg::NRN_FIRE) begin
            pot[nrn_idx] <= fire ? '0 : pot_leak;  // Reset on spike, else leak
        end
    end

    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (ev_valid) begin
                q_wr <= (q_wr == QA_W'(CREDITS - 1)) ? '0 : q_wr + 1'b1;
            end
            if (q_pop) begin
                q_rd <= (q_rd == QA_W'(CREDITS - 1)) ? '0 : q_rd + 1'b1;
            end
            q_cnt <= q_cnt + QC_W'(ev_valid) - QC_W'(q_pop);
        end
    end

    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            state       <= snn_pkg::NRN_IDLE;
            nrn_idx     <= '0;
            last_r      <= 1'b0;
            active      <= 1'b0;
            fire_last_d <= 1'b0;
            ev_credit   <= 1'b0;
            step_done   <= 1'b0;
            spike_valid <= 1'b0;
            spike_id    <= '0;
            clear       <= 1'b0;
            fire_last   <= 1'b0;
        end else begin
            ev_credit   <= q_pop;  // Retired event frees a slot
            clear       <= run_start;
            step_done   <= 1'b0;
            spike_valid <= 1'b0;
            fire_last   <= 1'b0;
            fire_last_d <= fire_last;
            // Held one cycle past fire_last, in line with the encoder's busy
            if (run_start) begin
                active <= 1'b1;
            end else if (fire_last_d) begin
                active <= 1'b0;
            end
            case (state)
                snn_pkg::NRN_IDLE: begin
                    nrn_idx <= '0;
                    if (step_end) begin
                        last_r <= run_last;
                        state  <= snn_pkg::NRN_FIRE;
                    end else if (q_cnt != '0) begin
                        state <= snn_pkg::NRN_INTEG;
                    end
                end
                snn_pkg::NRN_INTEG: begin
                    if (last_nrn) begin
                        nrn_idx <= '0;
                        if (q_cnt == QC_W'(1)) begin
                            state <= snn_pkg::NRN_IDLE;
                        end
                    end else begin
                        nrn_idx <= nrn_idx + 1'b1;
                    end
                end
                snn_pkg::NRN_FIRE: begin
                    if (fire) begin
                        spike_valid <= 1'b1;
                        spike_id    <= nrn_idx;
                    end
                    if (last_nrn) begin
                        nrn_idx   <= '0;
                        step_done <= 1'b1;
                        fire_last <= last_r;
                        state     <= snn_pkg::NRN_IDLE;
                    end else begin
                        nrn_idx <= nrn_idx + 1'b1;
                    end
                end
                default: state <= snn_pkg::NRN_IDLE;
            endcase
        end
    end

    a_queue_room: assert property (@(posedge SNN_CLK) disable iff (!RST_N)
        ev_valid |-> q_cnt < QC_W'(CREDITS));

    a_step_end_drained: assert property (@(posedge SNN_CLK) disable iff (!RST_N)
        step_end |-> (q_cnt == '0) && (state == snn_pkg::NRN_IDLE));

endmodule

//--- verilog/spike_tally.sv
`timescale 1ns/10ps

module spike_tally (
    input  logic             SNN_CLK,
    input  logic             RST_N,
    input  logic             clear,
    input  logic             spike_valid,
    input  snn_pkg::out_id_t spike_id,
    input  logic             fire_last,
    output logic             done,
    output snn_pkg::out_id_t result_class,
    output snn_pkg::count_t  result_count
);

    snn_pkg::count_t  cnt [snn_pkg::NUM_OUT];
    logic             search;
    snn_pkg::out_id_t best_id;
    snn_pkg::count_t  best_cnt;

    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            for (int i = 0; i < snn_pkg::NUM_OUT; i++) begin
                cnt[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < snn_pkg::NUM_OUT; i++) begin
                cnt[i] <= '0;
            end
        end else if (spike_valid && cnt[spike_id] != '1) begin  // Saturate
            cnt[spike_id] <= cnt[spike_id] + 1'b1;
        end
    end

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        best_id  = '0;
        best_cnt = cnt[0];
        for (int i = 1; i < snn_pkg::NUM_OUT; i++) begin
            if (cnt[i] > best_cnt) begin
                best_id  = snn_pkg::out_id_t'(i);
                best_cnt = cnt[i];
            end
        end
    end

    always_ff @(posedge SNN_CLK or negedge RST_N) begin
        if (!RST_N) begin
            search <= 1'b0;
            done   <= 1'b0;
        end else begin
            search <= fire_last;  // Last spike lands with fire_last
            done   <= search;
        end
    end

    always_ff @(posedge SNN_CLK) begin
        if (search) begin
            result_class <= best_id;
            result_count <= best_cnt;
        end
    end

endmodule

//--- verilog/snn_top.sv
`timescale 1ns/10ps

module snn_top #(
    parameter int NUM_IN     = 16,
    parameter int IN_ADDR_W  = 4,
    parameter int CREDITS    = 4,
    parameter int THRESHOLD  = 200,
    parameter int LEAK_SHIFT = 3
) (
    input  logic                       SNN_CLK,
    input  logic                       RST_N,
    // Host pixel writes
    input  logic                       pix_we,
    input  logic [IN_ADDR_W-1:0]       pix_addr,
    input  snn_pkg::pixel_t            pix_data,
    // Host weight writes
    input  logic                       w_we,
    input  logic [IN_ADDR_W-1:0]       w_in_addr,
    input  snn_pkg::out_id_t           w_out_id,
    input  snn_pkg::weight_t           w_data,
    // Run control
    input  logic                       start,
    input  logic [snn_pkg::STEP_W-1:0] num_steps,
    output logic                       busy,
    output logic                       done,
    // Output address-event stream
    output logic                       spike_valid,
    output snn_pkg::out_id_t           spike_id,
    // Classification result
    output snn_pkg::out_id_t           result_class,
    output snn_pkg::count_t            result_count
);

    logic                 ev_valid;
    logic [IN_ADDR_W-1:0] ev_addr;
    logic                 ev_credit;
    logic                 step_end;
    logic                 run_last;
    logic                 step_done;
    logic                 clear;
    logic                 fire_last;

    rate_encoder #(
        .NUM_IN    (NUM_IN),
        .IN_ADDR_W (IN_ADDR_W),
        .CREDITS   (CREDITS)
    ) encoder_i (
        .SNN_CLK   (SNN_CLK),
        .RST_N     (RST_N),
        .pix_we    (pix_we),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .start     (start),
        .num_steps (num_steps),
        .busy      (busy),
        .ev_valid  (ev_valid),
        .ev_addr   (ev_addr),
        .ev_credit (ev_credit),
        .step_end  (step_end),
        .run_last  (run_last),
        .step_done (step_done)
    );

    neuron_array #(
        .NUM_IN     (NUM_IN),
        .IN_ADDR_W  (IN_ADDR_W),
        .CREDITS    (CREDITS),
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT)
    ) neurons_i (
        .SNN_CLK     (SNN_CLK),
        .RST_N       (RST_N),
        .w_we        (w_we),
        .w_in_addr   (w_in_addr),
        .w_out_id    (w_out_id),
        .w_data      (w_data),
        .start       (start),
        .ev_valid    (ev_valid),
        .ev_addr     (ev_addr),
        .ev_credit   (ev_credit),
        .step_end    (step_end),
        .run_last    (run_last),
        .step_done   (step_done),
        .spike_valid (spike_valid),
        .spike_id    (spike_id),
        .clear       (clear),
        .fire_last   (fire_last)
    );

    spike_tally tally_i (
        .SNN_CLK      (SNN_CLK),
        .RST_N        (RST_N),
        .clear        (clear),
        .spike_valid  (spike_valid),
        .spike_id     (spike_id),
        .fire_last    (fire_last),
        .done         (done),
        .result_class (result_class),
        .result_count (result_count)
    );

endmodule

//--- testbench/snn_model.svh
`ifndef SNN_MODEL_SVH
`define SNN_MODEL_SVH

// Clamp to the signed membrane range
function automatic int sat_pot(input int v);
    int hi;
    int lo;
    hi = (1 << (snn_pkg::POT_W - 1)) - 1;
    lo = -(1 << (snn_pkg::POT_W - 1));
    if (v > hi) begin
        return hi;
    end
    if (v < lo) begin
        return lo;
    end
    return v;
endfunction

// Full run on m_pix and m_wt, fills exp_spikes, exp_class and exp_count
task automatic model_run(input int steps);
    int acc   [NUM_IN];
    int pot   [snn_pkg::NUM_OUT];
    int tally [snn_pkg::NUM_OUT];
    int s;
    int i;
    int n;
    int sum;
    exp_spikes.delete();
    for (i = 0; i < NUM_IN; i++) begin
        acc[i] = 0;
    end
    for (n = 0; n < snn_pkg::NUM_OUT; n++) begin
        pot[n]   = 0;
        tally[n] = 0;
    end
    for (s = 0; s < steps; s++) begin
        for (i = 0; i < NUM_IN; i++) begin
            sum    = acc[i] + int'(m_pix[i]);
            acc[i] = sum % (1 << snn_pkg::PIXEL_W);
            if (sum >= (1 << snn_pkg::PIXEL_W)) begin  // Phase wrapped
                for (n = 0; n < snn_pkg::NUM_OUT; n++) begin
                    pot[n] = sat_pot(pot[n] + int'(m_wt[i][n]));
                end
            end
        end
        for (n = 0; n < snn_pkg::NUM_OUT; n++) begin
            if (pot[n] >= THRESHOLD) begin
                exp_spikes.push_back(snn_pkg::out_id_t'(n));
                tally[n]++;
                pot[n] = 0;
            end else begin
                pot[n] = pot[n] - (pot[n] >>> LEAK_SHIFT);
            end
        end
    end
    exp_class = '0;
    exp_count = snn_pkg::count_t'(tally[0]);
    for (n = 1; n < snn_pkg::NUM_OUT; n++) begin
        if (tally[n] > int'(exp_count)) begin  // Lowest index keeps a tie
            exp_class = snn_pkg::out_id_t'(n);
            exp_count = snn_pkg::count_t'(tally[n]);
        end
    end
endtask

`endif

//--- testbench/tb_snn_top.sv
`timescale 1ns/10ps

module tb_snn_top;

    localparam int NUM_IN     = 16;
    localparam int IN_ADDR_W  = 4;
    localparam int CREDITS    = 4;
    localparam int THRESHOLD  = 200;
    localparam int LEAK_SHIFT = 3;
    localparam int STEP_W     = snn_pkg::STEP_W;
    localparam int NUM_RUNS   = 10;
    localparam int SEED       = 62854;

    logic                 SNN_CLK;
    logic                 RST_N;
    logic                 pix_we;
    logic [IN_ADDR_W-1:0] pix_addr;
    snn_pkg::pixel_t      pix_data;
    logic                 w_we;
    logic [IN_ADDR_W-1:0] w_in_addr;
    snn_pkg::out_id_t     w_out_id;
    snn_pkg::weight_t     w_data;
    logic                 start;
    logic [STEP_W-1:0]    num_steps;
    logic                 busy;
    logic                 done;
    logic                 spike_valid;
    snn_pkg::out_id_t     spike_id;
    snn_pkg::out_id_t     result_class;
    snn_pkg::count_t      result_count;

    integer           seed;
    int               run_steps [NUM_RUNS];
    int               total_steps;
    bit               plan_ready;
    int               val_errs;
    int               proto_errs;
    int               seen_upto;   // Spikes already accounted for
    snn_pkg::pixel_t  m_pix [NUM_IN];
    snn_pkg::weight_t m_wt  [NUM_IN][snn_pkg::NUM_OUT];
    snn_pkg::out_id_t exp_spikes [$];
    snn_pkg::out_id_t got_spikes [$];
    snn_pkg::out_id_t exp_class;
    snn_pkg::count_t  exp_count;

    `include "snn_model.svh"

    snn_top #(
        .NUM_IN     (NUM_IN),
        .IN_ADDR_W  (IN_ADDR_W),
        .CREDITS    (CREDITS),
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT)
    ) dut_i (
        .SNN_CLK      (SNN_CLK),
        .RST_N        (RST_N),
        .pix_we       (pix_we),
        .pix_addr     (pix_addr),
        .pix_data     (pix_data),
        .w_we         (w_we),
        .w_in_addr    (w_in_addr),
        .w_out_id     (w_out_id),
        .w_data       (w_data),
        .start        (start),
        .num_steps    (num_steps),
        .busy         (busy),
        .done         (done),
        .spike_valid  (spike_valid),
        .spike_id     (spike_id),
        .result_class (result_class),
        .result_count (result_count)
    );

    initial begin
        SNN_CLK = 1'b0;
        forever #5 SNN_CLK = ~SNN_CLK;
    end

    // Output event stream, sampled mid-cycle
    always @(negedge SNN_CLK) begin
        if (spike_valid) begin
            got_spikes.push_back(spike_id);
        end
    end

    task automatic check_id(input string name, input snn_pkg::out_id_t exp,
                            input snn_pkg::out_id_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_count(input string name, input snn_pkg::count_t exp,
                               input snn_pkg::count_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            val_errs++;
        end
    endtask

    // Kind 1 is a blank image, 2 and 3 are saturated images with extreme weights
    task automatic load_image(input int kind);
        int i;
        int n;
        for (i = 0; i < NUM_IN; i++) begin
            case (kind)
                1:       m_pix[i] = '0;
                2, 3:    m_pix[i] = '1;
                default: m_pix[i] = snn_pkg::pixel_t'($random(seed));
            endcase
            pix_we   = 1'b1;
            pix_addr = IN_ADDR_W'(i);
            pix_data = m_pix[i];
            @(negedge SNN_CLK);
            for (n = 0; n < snn_pkg::NUM_OUT; n++) begin
                case (kind)
                    2:       m_wt[i][n] = snn_pkg::weight_t'(127);
                    3:       m_wt[i][n] = snn_pkg::weight_t'(-128);
                    default: m_wt[i][n] = snn_pkg::weight_t'(($random(seed) % 64) + 16);
                endcase
                pix_we    = 1'b0;
                w_we      = 1'b1;
                w_in_addr = IN_ADDR_W'(i);
                w_out_id  = snn_pkg::out_id_t'(n);
                w_data    = m_wt[i][n];
                @(negedge SNN_CLK);
            end
            w_we = 1'b0;
        end
    endtask

    task automatic do_run(input int kind, input int steps);
        int i;
        load_image(kind);
        model_run(steps);
        if (got_spikes.size() != seen_upto) begin
            $display("Output spikes appeared while the network was idle");
            proto_errs++;
        end
        seen_upto = got_spikes.size();
        start     = 1'b1;
        num_steps = STEP_W'(steps);
        @(negedge SNN_CLK);
        start = 1'b0;
        @(negedge SNN_CLK);
        if (busy) begin
            // Host traffic during a run, none of it may land
            pix_we    = 1'b1;
            pix_addr  = IN_ADDR_W'({$random(seed)} % NUM_IN);
            pix_data  = snn_pkg::pixel_t'($random(seed));
            w_we      = 1'b1;
            w_in_addr = IN_ADDR_W'({$random(seed)} % NUM_IN);
            w_out_id  = snn_pkg::out_id_t'({$random(seed)} % snn_pkg::NUM_OUT);
            w_data    = snn_pkg::weight_t'($random(seed));
            start     = 1'b1;
            num_steps = '1;
            @(negedge SNN_CLK);
            pix_we = 1'b0;
            w_we   = 1'b0;
            start  = 1'b0;
        end else begin
            $display("busy did not rise after start");
            proto_errs++;
        end
        while (!done) begin
            @(negedge SNN_CLK);
        end
        check_flag("busy", 1'b0, busy);  // Falls with done
        check_count("spike_count", snn_pkg::count_t'(exp_spikes.size()),
                    snn_pkg::count_t'(got_spikes.size() - seen_upto));
        for (i = 0; i < exp_spikes.size() && seen_upto + i < got_spikes.size(); i++) begin
            check_id("spike_id", exp_spikes[i], got_spikes[seen_upto + i]);
        end
        seen_upto = got_spikes.size();
        check_id("result_class", exp_class, result_class);
        check_count("result_count", exp_count, result_count);
        @(negedge SNN_CLK);
        check_flag("done", 1'b0, done);
    endtask

    // Budget scales with the total step count
    initial begin
        wait (plan_ready);
        repeat (2000 * total_steps) @(posedge SNN_CLK);
        $display("Timeout, the runs did not finish within %0d cycles", 2000 * total_steps);
        $display("Errors: value %0d, protocol %0d", val_errs, proto_errs + 1);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int r;
        seed        = SEED;
        val_errs    = 0;
        proto_errs  = 0;
        seen_upto   = 0;
        total_steps = 0;
        plan_ready  = 1'b0;
        RST_N       = 1'b0;
        pix_we      = 1'b0;
        pix_addr    = '0;
        pix_data    = '0;
        w_we        = 1'b0;
        w_in_addr   = '0;
        w_out_id    = '0;
        w_data      = '0;
        start       = 1'b0;
        num_steps   = '0;
        for (r = 0; r < NUM_RUNS; r++) begin
            run_steps[r] = 1 + int'({$random(seed)} % 8);
            total_steps  = total_steps + run_steps[r];
        end
        plan_ready = 1'b1;
        repeat (5) @(negedge SNN_CLK);
        RST_N = 1'b1;
        repeat (5) begin  // Idle until the first start
            @(negedge SNN_CLK);
            check_flag("busy", 1'b0, busy);
            check_flag("done", 1'b0, done);
            check_flag("spike_valid", 1'b0, spike_valid);
        end
        for (r = 0; r < NUM_RUNS; r++) begin
            do_run((r < 4) ? r : 0, run_steps[r]);
        end
        $display("Errors: value %0d, protocol %0d", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+testbench
verilog/snn_pkg.sv
verilog/rate_encoder.sv
verilog/neuron_array.sv
verilog/spike_tally.sv
verilog/snn_top.sv
testbench/tb_snn_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_snn_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -e '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
